// File: hdl/rvCorePkg.sv
/* datapath vector types, RV32I major opcodes and ALU operations */
package rvCorePkg;

  typedef logic [31:0] data_t;
  typedef logic [31:0] addr_t; // byte address
  typedef logic [4:0]  regIdx_t;
  typedef logic [3:0]  byteEn_t; // one bit per byte lane

  typedef enum logic [6:0] {
    RType       = 7'b0110011,
    IType_logic = 7'b0010011,
    IType_load  = 7'b0000011,
    SType       = 7'b0100011,
    BType       = 7'b1100011,
    JType       = 7'b1101111,
    IType_jalr  = 7'b1100111,
    UType_lui   = 7'b0110111,
    UType_auipc = 7'b0010111,
    FENCE       = 7'b0001111
  } opcode_t;

  typedef enum logic [3:0] {
    AluAdd, AluSub, AluAnd, AluOr, AluXor, AluSll,
    AluSrl, AluSra, AluSlt, AluSltu, AluSge, AluSgeu
  } aluOp_t;

endpackage

// File: hdl/rvCtrlPkg.sv
/* control selects, FSM state encoding and the control struct sent to the datapath */
package rvCtrlPkg;

  typedef enum logic {AdrSrcPc, AdrSrcResult} adrSrc_t;
  typedef enum logic [1:0] {AluSrcAZero, AluSrcAOldPc, AluSrcARd1} aluSrcA_t;
  typedef enum logic [1:0] {AluSrcBRd2, AluSrcBImm, AluSrcBFour} aluSrcB_t;
  typedef enum logic {ResultAluOut, ResultData} resultSrc_t;
  typedef enum logic [1:0] {PcIncrement, PcJump, PcAluResult} pcSrc_t;

  // binary codes follow the original 5-bit state numbering
  typedef enum logic [4:0] {
    StFetch      = 5'd0,
    StDecode     = 5'd1,
    StExecuteR   = 5'd2,
    StUncondJump = 5'd3,
    StExecuteI   = 5'd4,
    StMemAdr     = 5'd5,
    StAluWb      = 5'd6,
    StMemWrite   = 5'd7,
    StMemRead    = 5'd8,
    StMemWb      = 5'd9,
    StBranchIfEq = 5'd10,
    StLui        = 5'd11,
    StAuipc      = 5'd12,
    StJalrCalc   = 5'd13,
    StJalrStep2  = 5'd14,
    StBranchComp = 5'd15
  } fsmState_t;

  typedef struct packed {
    adrSrc_t            adrSrc;
    aluSrcA_t           aluSrcA;
    aluSrcB_t           aluSrcB;
    resultSrc_t         resultSrc;
    pcSrc_t             pcSrc;
    logic               irWrite;
    logic               regWrite;
    logic               pcUpdate;
    logic               branch;
    rvCorePkg::byteEn_t memWrite; // zero when no store
  } ctrl_t;

endpackage

// File: hdl/controlFsm.sv
/* Moore control FSM for the multicycle RV32I core */
module controlFsm (
  input  logic                 clk,
  input  logic                 reset,
  input  rvCorePkg::opcode_t   opcode,
  input  logic [2:0]           funct3,
  input  logic                 zeroFlag,
  input  rvCorePkg::data_t     aluResult,
  input  rvCorePkg::byteEn_t   byteEn,
  output rvCtrlPkg::ctrl_t     ctrl,
  output rvCtrlPkg::fsmState_t state
);

  rvCtrlPkg::fsmState_t curState, nextState;

  assign state = curState;

  always_ff @(posedge clk) begin
    if (reset) curState <= rvCtrlPkg::StFetch;
    else curState <= nextState;
  end

  // next state
  always_comb begin
    nextState = rvCtrlPkg::StFetch;
    case (curState)
      rvCtrlPkg::StFetch: nextState = rvCtrlPkg::StDecode;
      rvCtrlPkg::StDecode: begin
        case (opcode)
          rvCorePkg::JType:       nextState = rvCtrlPkg::StUncondJump;
          rvCorePkg::RType:       nextState = rvCtrlPkg::StExecuteR;
          rvCorePkg::IType_logic: nextState = rvCtrlPkg::StExecuteI;
          rvCorePkg::IType_load:  nextState = rvCtrlPkg::StMemAdr;
          rvCorePkg::SType:       nextState = rvCtrlPkg::StMemAdr;
          rvCorePkg::BType: begin
            // beq and bne use the zero flag, the rest a compare result
            if (funct3[2:1] == 2'b00) nextState = rvCtrlPkg::StBranchIfEq;
            else nextState = rvCtrlPkg::StBranchComp;
          end
          rvCorePkg::UType_auipc: nextState = rvCtrlPkg::StAuipc;
          rvCorePkg::UType_lui:   nextState = rvCtrlPkg::StLui;
          rvCorePkg::IType_jalr:  nextState = rvCtrlPkg::StJalrCalc;
          rvCorePkg::FENCE:       nextState = rvCtrlPkg::StFetch; // no-op
          default:                nextState = rvCtrlPkg::StDecode; // unknown opcode parks here
        endcase
      end
      rvCtrlPkg::StMemAdr: begin
        if (opcode == rvCorePkg::IType_load) nextState = rvCtrlPkg::StMemRead;
        else if (opcode == rvCorePkg::SType) nextState = rvCtrlPkg::StMemWrite;
        else nextState = rvCtrlPkg::StMemAdr;
      end
      rvCtrlPkg::StExecuteR,
      rvCtrlPkg::StExecuteI,
      rvCtrlPkg::StLui,
      rvCtrlPkg::StAuipc,
      rvCtrlPkg::StUncondJump: nextState = rvCtrlPkg::StAluWb;
      rvCtrlPkg::StMemRead:    nextState = rvCtrlPkg::StMemWb;
      rvCtrlPkg::StJalrCalc:   nextState = rvCtrlPkg::StJalrStep2;
      rvCtrlPkg::StJalrStep2:  nextState = rvCtrlPkg::StAluWb;
      default:                 nextState = rvCtrlPkg::StFetch;
    endcase
  end

  // outputs depend on the state only, plus the branch decision
  always_comb begin
    ctrl.adrSrc    = rvCtrlPkg::AdrSrcPc;
    ctrl.aluSrcA   = rvCtrlPkg::AluSrcARd1;
    ctrl.aluSrcB   = rvCtrlPkg::AluSrcBRd2;
    ctrl.resultSrc = rvCtrlPkg::ResultAluOut;
    ctrl.pcSrc     = rvCtrlPkg::PcIncrement;
    ctrl.irWrite   = 1'b0;
    ctrl.regWrite  = 1'b0;
    ctrl.pcUpdate  = 1'b0;
    ctrl.branch    = 1'b0;
    ctrl.memWrite  = '0;
    case (curState)
      rvCtrlPkg::StFetch: begin
        ctrl.irWrite  = 1'b1;
        ctrl.pcUpdate = 1'b1; // pc + 4
      end
      rvCtrlPkg::StDecode, rvCtrlPkg::StAuipc: begin
        ctrl.aluSrcA = rvCtrlPkg::AluSrcAOldPc; // branch or jal target in decode
        ctrl.aluSrcB = rvCtrlPkg::AluSrcBImm;
      end
      rvCtrlPkg::StLui: begin
        ctrl.aluSrcA = rvCtrlPkg::AluSrcAZero;
        ctrl.aluSrcB = rvCtrlPkg::AluSrcBImm;
      end
      rvCtrlPkg::StExecuteI, rvCtrlPkg::StMemAdr: ctrl.aluSrcB = rvCtrlPkg::AluSrcBImm;
      rvCtrlPkg::StUncondJump: begin
        ctrl.aluSrcA  = rvCtrlPkg::AluSrcAOldPc; // link value
        ctrl.aluSrcB  = rvCtrlPkg::AluSrcBFour;
        ctrl.pcSrc    = rvCtrlPkg::PcJump;
        ctrl.pcUpdate = 1'b1;
      end
      rvCtrlPkg::StJalrCalc: begin
        // rs1 + imm goes straight into the pc
        ctrl.aluSrcB  = rvCtrlPkg::AluSrcBImm;
        ctrl.pcSrc    = rvCtrlPkg::PcAluResult;
        ctrl.pcUpdate = 1'b1;
      end
      rvCtrlPkg::StJalrStep2: begin
        ctrl.aluSrcA = rvCtrlPkg::AluSrcAOldPc;
        ctrl.aluSrcB = rvCtrlPkg::AluSrcBFour;
      end
      rvCtrlPkg::StBranchIfEq: begin
        ctrl.branch   = 1'b1;
        ctrl.pcSrc    = rvCtrlPkg::PcJump;
        ctrl.pcUpdate = funct3[0] ? !zeroFlag : zeroFlag; // bne : beq
      end
      rvCtrlPkg::StBranchComp: begin
        ctrl.branch   = 1'b1;
        ctrl.pcSrc    = rvCtrlPkg::PcJump;
        ctrl.pcUpdate = (aluResult == 32'd1);
      end
      rvCtrlPkg::StAluWb: ctrl.regWrite = 1'b1;
      rvCtrlPkg::StMemRead: ctrl.adrSrc = rvCtrlPkg::AdrSrcResult;
      rvCtrlPkg::StMemWrite: begin
        ctrl.adrSrc   = rvCtrlPkg::AdrSrcResult;
        ctrl.memWrite = byteEn;
      end
      rvCtrlPkg::StMemWb: begin
        ctrl.resultSrc = rvCtrlPkg::ResultData;
        ctrl.regWrite  = 1'b1;
      end
      default: ;
    endcase
  end

  // a single cycle never both writes back and stores
  assert property (@(posedge clk) disable iff (reset)
    !(ctrl.regWrite && (|ctrl.memWrite)));

  assert property (@(posedge clk) disable iff (reset) !$isunknown(curState));

endmodule

// File: hdl/aluUnit.sv
/* ALU and its operation decoder */
module aluUnit (
  input  rvCorePkg::data_t     a,
  input  rvCorePkg::data_t     b,
  input  rvCorePkg::data_t     instr,
  input  rvCtrlPkg::fsmState_t state,
  output rvCorePkg::data_t     result,
  output logic                 zeroFlag
);

  rvCorePkg::aluOp_t aluOp;
  logic [2:0] funct3;
  logic       funct7b5;

  assign funct3   = instr[14:12];
  assign funct7b5 = instr[30];

  always_comb begin
    aluOp = rvCorePkg::AluAdd; // address and pc arithmetic
    case (state)
      rvCtrlPkg::StExecuteR, rvCtrlPkg::StExecuteI: begin
        case (funct3)
          3'b000: begin
            // imm bit 30 of addi is not a sub
            if (state == rvCtrlPkg::StExecuteR && funct7b5) aluOp = rvCorePkg::AluSub;
            else aluOp = rvCorePkg::AluAdd;
          end
          3'b001:  aluOp = rvCorePkg::AluSll;
          3'b010:  aluOp = rvCorePkg::AluSlt;
          3'b011:  aluOp = rvCorePkg::AluSltu;
          3'b100:  aluOp = rvCorePkg::AluXor;
          3'b101:  aluOp = funct7b5 ? rvCorePkg::AluSra : rvCorePkg::AluSrl;
          3'b110:  aluOp = rvCorePkg::AluOr;
          default: aluOp = rvCorePkg::AluAnd;
        endcase
      end
      rvCtrlPkg::StBranchIfEq, rvCtrlPkg::StBranchComp: begin
        case (funct3)
          3'b100:  aluOp = rvCorePkg::AluSlt;  // blt
          3'b101:  aluOp = rvCorePkg::AluSge;  // bge
          3'b110:  aluOp = rvCorePkg::AluSltu; // bltu
          3'b111:  aluOp = rvCorePkg::AluSgeu; // bgeu
          default: aluOp = rvCorePkg::AluSub;  // beq, bne
        endcase
      end
      default: ;
    endcase
  end

  always_comb begin
    case (aluOp)
      rvCorePkg::AluSub:  result = a - b;
      rvCorePkg::AluAnd:  result = a & b;
      rvCorePkg::AluOr:   result = a | b;
      rvCorePkg::AluXor:  result = a ^ b;
      rvCorePkg::AluSll:  result = a << b[4:0];
      rvCorePkg::AluSrl:  result = a >> b[4:0];
      rvCorePkg::AluSra:  result = $signed(a) >>> b[4:0];
      rvCorePkg::AluSlt:  result = {31'b0, $signed(a) < $signed(b)};
      rvCorePkg::AluSltu: result = {31'b0, a < b};
      rvCorePkg::AluSge:  result = {31'b0, $signed(a) >= $signed(b)};
      rvCorePkg::AluSgeu: result = {31'b0, a >= b};
      default:            result = a + b;
    endcase
  end

  assign zeroFlag = (result == '0);

endmodule

// File: hdl/regFile.sv
/* 32 x 32 register file, two read ports and one write port */
module regFile (
  input  logic               clk,
  input  rvCorePkg::regIdx_t ra1,
  input  rvCorePkg::regIdx_t ra2,
  input  rvCorePkg::regIdx_t wa,
  input  logic               we,
  input  rvCorePkg::data_t   wd,
  output rvCorePkg::data_t   rd1,
  output rvCorePkg::data_t   rd2
);

  rvCorePkg::data_t regs [32];

  always_ff @(posedge clk) begin
    if (we && wa != '0) begin
      regs[wa] <= wd; // x0 stays zero
    end
  end

  // entry 0 is never written, so force it on read
  assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
  assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

// File: hdl/datapath.sv
/* core datapath: pc and state registers, immediates, operand and address muxes,
   store lane alignment */
module datapath #(
  parameter rvCorePkg::addr_t resetPc = '0
) (
  input  logic                 clk,
  input  logic                 reset,
  input  rvCtrlPkg::ctrl_t     ctrl,
  input  rvCtrlPkg::fsmState_t state,
  input  rvCorePkg::data_t     memRData,
  output rvCorePkg::addr_t     memAddr,
  output rvCorePkg::data_t     memWData,
  output rvCorePkg::opcode_t   opcode,
  output logic [2:0]           funct3,
  output logic                 zeroFlag,
  output rvCorePkg::data_t     aluResult,
  output rvCorePkg::byteEn_t   byteEn
);

  rvCorePkg::addr_t pc, oldPc, pcNext;
  rvCorePkg::data_t instr, dataReg, aluOut;
  rvCorePkg::data_t rd1, rd2, immExt, srcA, srcB, result;
  logic [1:0] addrLow;

  assign opcode = rvCorePkg::opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];

  always_comb begin
    case (ctrl.pcSrc)
      rvCtrlPkg::PcJump:      pcNext = aluOut; // target from decode
      rvCtrlPkg::PcAluResult: pcNext = {aluResult[31:1], 1'b0};
      default:                pcNext = pc + 32'd4;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) pc <= resetPc;
    else if (ctrl.pcUpdate) pc <= pcNext;
  end

  always_ff @(posedge clk) begin
    if (ctrl.irWrite) begin
      instr <= memRData;
      oldPc <= pc;
    end
    dataReg <= memRData; // both capture every cycle
    aluOut  <= aluResult;
  end

  always_comb begin
    case (opcode)
      rvCorePkg::SType: immExt = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      rvCorePkg::BType:
        immExt = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      rvCorePkg::JType:
        immExt = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      rvCorePkg::UType_lui, rvCorePkg::UType_auipc: immExt = {instr[31:12], 12'b0};
      default: immExt = {{20{instr[31]}}, instr[31:20]}; // I format
    endcase
  end

  regFile regFile_inst (
    .clk(clk),
    .ra1(instr[19:15]),
    .ra2(instr[24:20]),
    .wa (instr[11:7]),
    .we (ctrl.regWrite),
    .wd (result),
    .rd1(rd1),
    .rd2(rd2)
  );

  always_comb begin
    case (ctrl.aluSrcA)
      rvCtrlPkg::AluSrcAZero:  srcA = '0;
      rvCtrlPkg::AluSrcAOldPc: srcA = oldPc;
      default:                 srcA = rd1;
    endcase
    case (ctrl.aluSrcB)
      rvCtrlPkg::AluSrcBImm:  srcB = immExt;
      rvCtrlPkg::AluSrcBFour: srcB = 32'd4;
      default:                srcB = rd2;
    endcase
  end

  aluUnit aluUnit_inst (
    .a       (srcA),
    .b       (srcB),
    .instr   (instr),
    .state   (state),
    .result  (aluResult),
    .zeroFlag(zeroFlag)
  );

  assign result  = (ctrl.resultSrc == rvCtrlPkg::ResultData) ? dataReg : aluOut;
  assign memAddr = (ctrl.adrSrc == rvCtrlPkg::AdrSrcResult) ? result : pc;

  // store address sits in aluOut during the store cycle
  assign addrLow  = aluOut[1:0];
  assign memWData = rd2 << {addrLow, 3'b000};

  always_comb begin
    case (funct3[1:0])
      2'b00:   byteEn = 4'b0001 << addrLow; // sb
      2'b01:   byteEn = 4'b0011 << addrLow; // sh
      default: byteEn = 4'b1111;
    endcase
  end

endmodule

// File: hdl/unifiedMemory.sv
/* unified instruction and data memory with byte-lane writes and a program load port */
module unifiedMemory #(
  parameter int depthWords = 256
) (
  input  logic               clk,
  input  rvCorePkg::addr_t   addr,
  input  rvCorePkg::data_t   wdata,
  input  rvCorePkg::byteEn_t we,
  output rvCorePkg::data_t   rdata,
  input  logic               loadEn,
  input  rvCorePkg::addr_t   loadAddr,
  input  rvCorePkg::data_t   loadData
);

  localparam int idxBits = $clog2(depthWords);

  rvCorePkg::data_t mem [depthWords];
  logic [idxBits-1:0] wordIdx, loadIdx;

  assign wordIdx = addr[idxBits+1:2]; // byte address to word index
  assign loadIdx = loadAddr[idxBits+1:2];

  always_ff @(posedge clk) begin
    if (loadEn) begin
      mem[loadIdx] <= loadData;
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (we[i]) mem[wordIdx][8*i +: 8] <= wdata[8*i +: 8];
      end
    end
  end

  assign rdata = mem[wordIdx];

  // core stores must land inside the array, no wrap
  assert property (@(posedge clk) (|we) |-> (addr[31:2] < depthWords));

endmodule

// File: hdl/multicycleCpu.sv
/* multicycle RV32I top: control FSM, datapath, memory and the store stream */
module multicycleCpu #(
  parameter int               depthWords = 256,
  parameter rvCorePkg::addr_t resetPc    = '0
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               loadEn,
  input  rvCorePkg::addr_t   loadAddr,
  input  rvCorePkg::data_t   loadData,
  output logic               storeValid,
  output rvCorePkg::addr_t   storeAddr,
  output rvCorePkg::data_t   storeData,
  output rvCorePkg::byteEn_t storeMask
);

  rvCtrlPkg::ctrl_t     ctrl;
  rvCtrlPkg::fsmState_t state;
  rvCorePkg::opcode_t   opcode;
  logic [2:0]           funct3;
  logic                 zeroFlag;
  rvCorePkg::data_t     aluResult, memWData, memRData;
  rvCorePkg::byteEn_t   byteEn;
  rvCorePkg::addr_t     memAddr;

  controlFsm controlFsm_inst (
    .clk(clk), .reset(reset),
    .opcode(opcode), .funct3(funct3), .zeroFlag(zeroFlag),
    .aluResult(aluResult), .byteEn(byteEn),
    .ctrl(ctrl), .state(state)
  );

  datapath #(.resetPc(resetPc)) datapath_inst (
    .clk(clk), .reset(reset), .ctrl(ctrl), .state(state),
    .memRData(memRData), .memAddr(memAddr), .memWData(memWData),
    .opcode(opcode), .funct3(funct3), .zeroFlag(zeroFlag),
    .aluResult(aluResult), .byteEn(byteEn)
  );

  unifiedMemory #(.depthWords(depthWords)) unifiedMemory_inst (
    .clk(clk), .addr(memAddr), .wdata(memWData), .we(ctrl.memWrite), .rdata(memRData),
    .loadEn(loadEn && reset), // program load only while held in reset
    .loadAddr(loadAddr), .loadData(loadData)
  );

  assign storeValid = |ctrl.memWrite;
  assign storeAddr  = {memAddr[31:2], 2'b00};
  assign storeData  = memWData;
  assign storeMask  = ctrl.memWrite;

endmodule

// File: test/multicycleCpuTb.sv
/* testbench for the multicycle RV32I core: program load through the load port,
   store stream checks against expected records, watchdog */
module multicycleCpuTb;

  localparam int clkPeriod   = 4;
  localparam int stimWords   = 256;
  localparam int numTests    = 6;
  localparam int drainCycles = 20; // quiet window after the last expected store

  logic               clk;
  logic               reset;
  logic               loadEn;
  rvCorePkg::addr_t   loadAddr;
  rvCorePkg::data_t   loadData;
  logic               storeValid;
  rvCorePkg::addr_t   storeAddr;
  rvCorePkg::data_t   storeData;
  rvCorePkg::byteEn_t storeMask;

  logic [31:0] stim [stimWords]; // counts, program words, then store records
  string       testNames [numTests];
  int          testChecks [numTests];
  int          testErrors [numTests];
  int          numProg;
  int          numRecs;
  int          recIdx;
  int          checkCount;
  int          errorCount;
  logic        started;

  multicycleCpu #(
    .depthWords(256),
    .resetPc   (32'h0000_0000)
  ) multicycleCpu_inst (
    .clk       (clk),
    .reset     (reset),
    .loadEn    (loadEn),
    .loadAddr  (loadAddr),
    .loadData  (loadData),
    .storeValid(storeValid),
    .storeAddr (storeAddr),
    .storeData (storeData),
    .storeMask (storeMask)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  task automatic compareValue(input int testIdx, input string field,
                              input logic [31:0] expected, input logic [31:0] actual);
    checkCount++;
    testChecks[testIdx]++;
    if (actual !== expected) begin
      errorCount++;
      testErrors[testIdx]++;
      $display("mismatch in %s (%s): expected %h, actual %h",
               testNames[testIdx], field, expected, actual);
    end
  endtask

  task automatic reportTest(input int testIdx);
    $display("test %s: %0d checks, %0d errors",
             testNames[testIdx], testChecks[testIdx], testErrors[testIdx]);
  endtask

  // compare one observed store with the next expected record
  task automatic checkStore();
    int base;
    int testIdx;
    if (recIdx >= numRecs) begin
      errorCount++;
      $display("unexpected store to %h after the last expected one", storeAddr);
    end else begin
      base    = 2 + numProg + 4 * recIdx;
      testIdx = stim[base];
      compareValue(testIdx, "addr", stim[base + 1], storeAddr);
      compareValue(testIdx, "data", stim[base + 2], storeData);
      compareValue(testIdx, "mask", stim[base + 3], 32'(storeMask));
      recIdx++;
      if (recIdx == numRecs || stim[base + 4] != testIdx) reportTest(testIdx); // group done
    end
  endtask

  // store strobes last one cycle, so each is seen at exactly one falling edge
  always @(negedge clk) begin
    if (!reset && storeValid) checkStore();
  end

  initial begin
    reset      = 1'b1;
    loadEn     = 1'b0;
    loadAddr   = '0;
    loadData   = '0;
    started    = 1'b0;
    recIdx     = 0;
    checkCount = 0;
    errorCount = 0;
    testNames  = '{"resetQuiet", "aluOps", "subwordStores", "branches", "jumps", "upperImm"};
    foreach (testChecks[i]) begin
      testChecks[i] = 0;
      testErrors[i] = 0;
    end
    $readmemh("test/cpuStimulus.txt", stim);
    numProg = stim[0];
    numRecs = stim[1];
    if (numProg == 0 || numRecs == 0) begin
      errorCount++;
      $display("stimulus file is empty or missing");
    end

    // program load while reset holds the core, no store may appear
    for (int i = 0; i < numProg; i++) begin
      @(negedge clk);
      compareValue(0, "storeValid", 32'd0, 32'(storeValid));
      loadEn   = 1'b1;
      loadAddr = i * 4;
      loadData = stim[2 + i];
    end
    @(negedge clk);
    loadEn = 1'b0;
    repeat (3) begin
      @(negedge clk);
      compareValue(0, "storeValid", 32'd0, 32'(storeValid));
    end
    reportTest(0);
    reset   = 1'b0;
    started = 1'b1;

    wait (recIdx == numRecs);
    repeat (drainCycles) @(negedge clk); // core spins in its final self loop
    $display("summary: %0d checks, %0d errors, %0d of %0d stores seen",
             checkCount, errorCount, recIdx, numRecs);
    if (errorCount == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // about 6 cycles per program word plus margin, counted from reset release
  initial begin
    wait (started === 1'b1);
    repeat (numProg * 6 + 100) @(posedge clk);
    $display("timeout: stores stopped arriving, %0d of %0d seen", recIdx, numRecs);
    $display("Test FAILED");
    $finish;
  end

endmodule

// File: multicycleCpu.f
hdl/rvCorePkg.sv
hdl/rvCtrlPkg.sv
hdl/controlFsm.sv
hdl/aluUnit.sv
hdl/regFile.sv
hdl/datapath.sv
hdl/unifiedMemory.sv
hdl/multicycleCpu.sv
test/multicycleCpuTb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = multicycleCpuTb
FILELIST  = multicycleCpu.f
OBJDIR    = obj_dir
PASS      = Test OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf $(OBJDIR)

// File: test/cpuStimulus.txt
// first line: program word count, store record count; then the program words from address 0
// then one store record per line: test index, word address, data, byte mask (all hex)
47 1c
20000513 ff900093 00300113            // x10 = 0x200, x1 = -7, x2 = 3
002081b3 00352023 402081b3 00352223   // add, sw; sub, sw
002091b3 00352423 0020d1b3 00352623   // sll, sw; srl, sw
4020d1b3 00352823 0020a1b3 00352a23   // sra, sw; slt, sw
0020b1b3 00352c23 0f50c193 00352e23   // sltu, sw; xori 0xf5, sw
4010d193 02352023 fff13193 02352223   // srai 1, sw; sltiu -1, sw
1a500213 04152023 04451123 044500a3   // x4 = 0x1a5; sw x1,64; sh x4,66; sb x4,65
04250023 04251023 04250123 044501a3   // sb x2,64; sh x2,64; sb x2,66; sb x4,67
04052283 04552223                     // lw x5,64; sw x5,68
00108463 06052e23 00208463 08252023   // beq taken, skipped sw; beq not taken, marker
00209463 06052e23 00211463 08252223   // bne
0020c463 06052e23 00114463 08252423   // blt
00115463 06052e23 0020d463 08252623   // bge
00116463 06052e23 0020e463 08252823   // bltu
0020f463 06052e23 00117463 08252a23   // bgeu
008003ef 06052e23 0a752023            // jal x7,+8 at 0xe4; skipped sw; sw x7,160
10100413 000404e7 06052e23 06052e23   // x8 = 0x101; jalr x9,0(x8) at 0xf4; two skipped
0a952223                              // sw x9,164 at 0x100
0ff0000f abcde5b7 0ab52823            // fence; lui x11,0xabcde; sw x11,176
12345617 0ac52a23 0000006f            // auipc x12,0x12345 at 0x110; sw x12,180; jal x0,0
1 00000200 fffffffc f
1 00000204 fffffff6 f
1 00000208 ffffffc8 f
1 0000020c 1fffffff f
1 00000210 ffffffff f
1 00000214 00000001 f
1 00000218 00000000 f
1 0000021c ffffff0c f
1 00000220 fffffffc f
1 00000224 00000001 f
2 00000240 fffffff9 f
2 00000240 01a50000 c
2 00000240 0001a500 2
2 00000240 00000003 1
2 00000240 00000003 3
2 00000240 00030000 4
2 00000240 a5000000 8
2 00000244 a5030003 f
3 00000280 00000003 f
3 00000284 00000003 f
3 00000288 00000003 f
3 0000028c 00000003 f
3 00000290 00000003 f
3 00000294 00000003 f
4 000002a0 000000e8 f
4 000002a4 000000f8 f
5 000002b0 abcde000 f
5 000002b4 12345110 f
